/* verilog.f */
src/hyper_pkg.sv
src/hyper_tx_fifo.sv
src/hyper_rx_fifo.sv
src/hyper_ddr_io.sv
src/hyper_phy_fsm.sv
src/hyper_phy.sv
bench/hyper_mem_model.sv
bench/tb_hyper_phy.sv

/* Makefile */
# Verilator build and run of the HyperBus PHY testbench

VERILATOR ?= verilator
TOP       ?= tb_hyper_phy
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/tb_hyper_phy.sv */
`timescale 1ns/10ps

// testbench for the HyperBus PHY, HyperRAM model on chip select 0
// runs a table of write, read and register tests against a shadow memory

module tb_hyper_phy;

    localparam int unsigned WAIT_CYCLES  = 6;
    localparam int          NR_TESTS     = 7;
    localparam int          RESET_CYCLES = 10;

    typedef struct packed {
        logic        write;
        logic [31:0] addr;
        logic [1:0]  cs;
        logic [11:0] burst;
        logic        reg_space;
        logic [15:0] seed;  // first data word
        logic [1:0]  strb;
        logic        bp;    // random gaps on tx_valid_i and rx_ready_i
    } test_t;

    logic                    clk0;
    logic                    rst_ni;
    logic                    trans_valid_i;
    logic                    trans_ready_o;
    hyper_pkg::hyper_req_t   trans_req_i;
    logic                    tx_valid_i;
    logic                    tx_ready_o;
    hyper_pkg::hyper_wdata_t tx_data_i;
    logic                    rx_valid_o;
    logic                    rx_ready_i;
    logic [15:0]             rx_data_o;
    logic [1:0]              hyper_cs_no;
    logic                    hyper_ck_o;
    logic                    hyper_ck_no;
    logic [7:0]              hyper_dq_o;
    logic [7:0]              hyper_dq_i;
    logic                    hyper_dq_oe_o;
    logic                    hyper_rwds_o;
    logic                    hyper_rwds_i;
    logic                    hyper_rwds_oe_o;
    logic                    hyper_reset_no;
    logic [47:0]             model_ca;
    logic [11:0]             model_words;
    logic [15:0]             model_reg;

    test_t       tests [NR_TESTS];
    logic [15:0] shadow [256];
    logic [1:0]  cs_seen;
    int          errors;
    int          checks;
    int          cycles;
    int          cycle_limit;
    int          cs_falls;
    int          cs_high_cnt;

    hyper_phy #(
        .WAIT_CYCLES(WAIT_CYCLES),
        .NR_CS      (2),
        .FIFO_DEPTH (8)
    ) DUT (.*);

    hyper_mem_model #(.WAIT_CYCLES(WAIT_CYCLES)) i_mem (
        .clk0   (clk0),
        .cs_ni  (hyper_cs_no[0]),
        .ck_i   (hyper_ck_o),
        .dq_i   (hyper_dq_o),
        .rwds_i (hyper_rwds_o),
        .dq_o   (hyper_dq_i),
        .rwds_o (hyper_rwds_i),
        .ca_o   (model_ca),
        .words_o(model_words),
        .reg_o  (model_reg)
    );

    initial begin
        clk0 = 1'b0;
        forever #10 clk0 = ~clk0;
    end

    always @(posedge clk0) begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit) begin
            $display("timeout: the DUT did not finish within %0d cycles", cycle_limit);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // chip select activity and recovery gap
    always @(negedge clk0) begin
        if (rst_ni) begin
            check_value("hyper_ck_no", hyper_ck_no, !hyper_ck_o);
            cs_seen = cs_seen | ~hyper_cs_no;
            if (&hyper_cs_no) begin
                cs_high_cnt++;
            end else if (cs_high_cnt != 0) begin
                cs_falls++;
                checks++;
                assert (cs_high_cnt >= int'(hyper_pkg::T_RWR_CYCLES)) else begin
                    $display("chip select was high for only %0d cycles between transactions",
                             cs_high_cnt);
                    errors++;
                end
                cs_high_cnt = 0;
            end
        end
    end

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        assert (got == exp) else begin
            $display("Error: %s = %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    function automatic logic [15:0] test_word(input logic [15:0] seed, input int i);
        return seed + 16'(i) * 16'h1013;
    endfunction

    task automatic run_test(input int t);
        test_t       e;
        int          pushed;
        int          got;
        int          falls0;
        int          err0;
        logic        accepted;
        logic        done;
        logic [7:0]  a;
        logic [15:0] w;
        logic [47:0] exp_ca;
        e        = tests[t];
        pushed   = 0;
        got      = 0;
        falls0   = cs_falls;
        err0     = errors;
        accepted = 1'b0;
        done     = 1'b0;
        @(posedge clk0);
        #2 cs_seen = '0;
        while (!done) begin
            trans_valid_i = !accepted;
            trans_req_i   = '{addr: e.addr, cs: e.cs, write: e.write,
                              reg_space: e.reg_space, burst: e.burst};
            tx_valid_i    = e.write && (pushed < int'(e.burst)) &&
                            (!e.bp || ($urandom % 3 == 0));
            tx_data_i     = '{data: test_word(e.seed, pushed), strb: e.strb};
            rx_ready_i    = !e.bp || ($urandom % 3 == 0);
            @(negedge clk0);
            if (tx_valid_i && tx_ready_o)
                pushed++;
            if (rx_valid_o && rx_ready_i) begin
                checks++;
                assert (!e.write) else begin
                    $display("a read word arrived during write test %0d", t);
                    errors++;
                end
                a = e.addr[7:0] + 8'(got);
                check_value($sformatf("rx_data_o word %0d", got), rx_data_o, shadow[a]);
                got++;
            end
            if (accepted && trans_ready_o && (e.write || got >= int'(e.burst)))
                done = 1'b1;
            if (trans_valid_i && trans_ready_o)
                accepted = 1'b1;
            @(posedge clk0);
            #2;
        end
        tx_valid_i = 1'b0;
        rx_ready_i = 1'b0;
        exp_ca = {~e.write, e.reg_space, 1'b1, e.addr[31:3], 13'd0, e.addr[2:0]};
        check_value("hyper_cs_no low bits", cs_seen, e.cs);
        check_value("chip select falls", cs_falls - falls0, 1);
        check_value("command/address", model_ca, exp_ca);
        check_value("data words", model_words, e.burst);
        if (e.write && e.reg_space)
            check_value("register", model_reg, test_word(e.seed, 0));
        if (e.write && !e.reg_space) begin
            for (int i = 0; i < int'(e.burst); i++) begin
                a = e.addr[7:0] + 8'(i);
                w = test_word(e.seed, i);
                if (e.strb[1])
                    shadow[a][15:8] = w[15:8];
                if (e.strb[0])
                    shadow[a][7:0] = w[7:0];
            end
        end
        $display("test %0d %s addr %h burst %0d: %0d errors", t,
                 e.write ? "write" : "read", e.addr, e.burst, errors - err0);
    endtask

    initial begin
        void'($urandom(32'h040f_63b5));
        // write, addr, cs, burst, reg_space, seed, strb, bp
        tests[0] = '{1'b1, 32'h0003_0010, 2'b01, 12'd4, 1'b0, 16'h1200, 2'b11, 1'b0};
        tests[1] = '{1'b0, 32'h0003_0010, 2'b01, 12'd4, 1'b0, 16'h0000, 2'b11, 1'b0};
        tests[2] = '{1'b1, 32'h0003_0010, 2'b01, 12'd4, 1'b0, 16'h5ac0, 2'b01, 1'b0};
        tests[3] = '{1'b0, 32'h0003_0010, 2'b01, 12'd4, 1'b0, 16'h0000, 2'b11, 1'b0};
        tests[4] = '{1'b1, 32'h0000_0801, 2'b01, 12'd1, 1'b1, 16'h8f1c, 2'b11, 1'b0};
        tests[5] = '{1'b1, 32'h1234_5675, 2'b01, 12'd8, 1'b0, 16'h3300, 2'b11, 1'b1};
        tests[6] = '{1'b0, 32'h1234_5675, 2'b01, 12'd8, 1'b0, 16'h0000, 2'b11, 1'b1};
        for (int i = 0; i < 256; i++)
            shadow[i] = {~8'(i), 8'(i)}; // same fill as the model
        cycle_limit = 0;
        for (int t = 0; t < NR_TESTS; t++)
            cycle_limit += int'(2 * WAIT_CYCLES) + 4 * int'(tests[t].burst) + 20;
        cycle_limit = 4 * cycle_limit + RESET_CYCLES;
        cycles        = 0;
        errors        = 0;
        checks        = 0;
        cs_falls      = 0;
        cs_high_cnt   = 100;
        cs_seen       = '0;
        trans_valid_i = 1'b0;
        trans_req_i   = '0;
        tx_valid_i    = 1'b0;
        tx_data_i     = '0;
        rx_ready_i    = 1'b0;
        rst_ni        = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk0);
        #2 rst_ni = 1'b1;
        @(negedge clk0);
        check_value("hyper_cs_no", hyper_cs_no, 2'b11);
        check_value("hyper_ck_o", hyper_ck_o, 1'b0);
        check_value("hyper_dq_oe_o", hyper_dq_oe_o, 1'b0);
        check_value("hyper_rwds_oe_o", hyper_rwds_oe_o, 1'b0);
        check_value("trans_ready_o", trans_ready_o, 1'b1);
        check_value("rx_valid_o", rx_valid_o, 1'b0);
        check_value("hyper_reset_no", hyper_reset_no, 1'b1);
        $display("test reset state: %0d errors", errors);
        for (int t = 0; t < NR_TESTS; t++)
            run_test(t);
        $display("%0d tests, %0d checks, %0d errors", NR_TESTS + 1, checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* bench/hyper_mem_model.sv */
`timescale 1ns/10ps

// behavioral HyperRAM for the PHY testbench, one byte per ck edge
// reports the last command/address word, its data word count and the register value

module hyper_mem_model #(
    parameter int unsigned WAIT_CYCLES = 6
) (
    input  logic        clk0,
    input  logic        cs_ni,
    input  logic        ck_i,
    input  logic [7:0]  dq_i,
    input  logic        rwds_i,
    output logic [7:0]  dq_o,
    output logic        rwds_o,
    output logic [47:0] ca_o,
    output logic [11:0] words_o,
    output logic [15:0] reg_o
);

    logic [15:0] mem [256];
    logic [47:0] ca_q;
    logic        ck_last;
    logic [7:0]  hi_byte;
    logic        hi_mask;
    logic [7:0]  idx;
    int          nbytes; // ck edges since chip select fell
    int          dpos;   // data byte position, negative in latency

    function automatic int lat_bytes(input logic [47:0] ca);
        return (ca[46] && !ca[47]) ? 0 : int'(2 * WAIT_CYCLES); // register write has none
    endfunction

    initial begin
        for (int i = 0; i < 256; i++)
            mem[i] = {~8'(i), 8'(i)};
        dq_o    = '0;
        rwds_o  = 1'b0;
        ca_o    = '0;
        words_o = '0;
        reg_o   = '0;
        ca_q    = '0;
        ck_last = 1'b0;
        hi_byte = '0;
        hi_mask = 1'b0;
        nbytes  = 0;
    end

    always @(negedge clk0) begin
        ck_last <= ck_i;
        dpos = nbytes - 6 - lat_bytes(ca_q);
        idx  = {ca_q[20:16], ca_q[2:0]} + 8'(dpos / 2);
        if (cs_ni) begin
            if (nbytes != 0) begin
                ca_o    <= ca_q;
                words_o <= 12'(dpos / 2);
            end
            nbytes <= 0;
        end else if (ck_i != ck_last) begin
            nbytes <= nbytes + 1;
            if (nbytes < 6) begin
                ca_q <= {ca_q[39:0], dq_i}; // command/address, high byte first
            end else if (dpos >= 0 && ca_q[47]) begin
                dq_o   <= dpos[0] ? mem[idx][7:0] : mem[idx][15:8];
                rwds_o <= ~rwds_o; // one rwds edge per read byte
            end else if (dpos >= 0 && !dpos[0]) begin
                hi_byte <= dq_i;
                hi_mask <= rwds_i;
            end else if (dpos >= 0 && ca_q[46]) begin
                reg_o <= {hi_byte, dq_i};
            end else if (dpos >= 0) begin
                if (!hi_mask)
                    mem[idx][15:8] <= hi_byte;
                if (!rwds_i)
                    mem[idx][7:0] <= dq_i;
            end
        end
    end

endmodule

/* src/hyper_phy.sv */
`timescale 1ns/10ps

// HyperBus PHY top level, single clock domain
// one request at a time on the trans port, write data in through tx, read data out on rx

module hyper_phy #(
    parameter int unsigned WAIT_CYCLES = 6,
    parameter int unsigned NR_CS       = 2,
    parameter int unsigned FIFO_DEPTH  = 8
) (
    input  logic                    clk0,
    input  logic                    rst_ni,
    input  logic                    trans_valid_i,
    output logic                    trans_ready_o,
    input  hyper_pkg::hyper_req_t   trans_req_i,
    input  logic                    tx_valid_i,
    output logic                    tx_ready_o,
    input  hyper_pkg::hyper_wdata_t tx_data_i,
    output logic                    rx_valid_o,
    input  logic                    rx_ready_i,
    output logic [15:0]             rx_data_o,
    output logic [NR_CS-1:0]        hyper_cs_no,
    output logic                    hyper_ck_o,
    output logic                    hyper_ck_no,
    output logic [7:0]              hyper_dq_o,
    input  logic [7:0]              hyper_dq_i,
    output logic                    hyper_dq_oe_o,
    output logic                    hyper_rwds_o,
    input  logic                    hyper_rwds_i,
    output logic                    hyper_rwds_oe_o,
    output logic                    hyper_reset_no
);

    hyper_pkg::hyper_wdata_t wdata;
    logic                    wempty;
    logic                    wpop;
    logic                    rfull;
    logic [15:0]             out_word;
    logic [1:0]              out_mask;
    logic                    byte_sel;
    logic                    ck_en;
    logic                    capture_en;
    logic [15:0]             rx_word;
    logic                    rx_word_valid;

    assign hyper_reset_no = 1'b1; // device never held in reset

    hyper_phy_fsm #(
        .WAIT_CYCLES(WAIT_CYCLES),
        .NR_CS      (NR_CS)
    ) i_fsm (
        .clk0         (clk0),
        .rst_ni       (rst_ni),
        .trans_valid_i(trans_valid_i),
        .trans_ready_o(trans_ready_o),
        .trans_req_i  (trans_req_i),
        .wdata_i      (wdata),
        .wempty_i     (wempty),
        .wpop_o       (wpop),
        .rfull_i      (rfull),
        .out_word_o   (out_word),
        .out_mask_o   (out_mask),
        .byte_sel_o   (byte_sel),
        .ck_en_o      (ck_en),
        .capture_en_o (capture_en),
        .dq_oe_o      (hyper_dq_oe_o),
        .rwds_oe_o    (hyper_rwds_oe_o),
        .cs_no        (hyper_cs_no)
    );

    hyper_tx_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) i_tx_fifo (
        .clk0   (clk0),
        .rst_ni (rst_ni),
        .valid_i(tx_valid_i),
        .ready_o(tx_ready_o),
        .data_i (tx_data_i),
        .pop_i  (wpop),
        .data_o (wdata),
        .empty_o(wempty)
    );

    hyper_rx_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) i_rx_fifo (
        .clk0         (clk0),
        .rst_ni       (rst_ni),
        .push_i       (rx_word_valid),
        .data_i       (rx_word),
        .almost_full_o(rfull),
        .valid_o      (rx_valid_o),
        .ready_i      (rx_ready_i),
        .data_o       (rx_data_o)
    );

    hyper_ddr_io i_ddr_io (
        .clk0        (clk0),
        .rst_ni      (rst_ni),
        .out_word_i  (out_word),
        .out_mask_i  (out_mask),
        .byte_sel_i  (byte_sel),
        .ck_en_i     (ck_en),
        .capture_en_i(capture_en),
        .hyper_dq_i  (hyper_dq_i),
        .hyper_rwds_i(hyper_rwds_i),
        .hyper_dq_o  (hyper_dq_o),
        .hyper_rwds_o(hyper_rwds_o),
        .hyper_ck_o  (hyper_ck_o),
        .hyper_ck_no (hyper_ck_no),
        .word_o      (rx_word),
        .word_valid_o(rx_word_valid)
    );

endmodule

/* src/hyper_phy_fsm.sv */
`timescale 1ns/10ps

// transaction FSM of the HyperBus PHY
// selects one byte per clk0 for the I/O block; pins follow its outputs one cycle later

module hyper_phy_fsm #(
    parameter int unsigned WAIT_CYCLES = 6,
    parameter int unsigned NR_CS       = 2
) (
    input  logic                    clk0,
    input  logic                    rst_ni,
    input  logic                    trans_valid_i,
    output logic                    trans_ready_o,
    input  hyper_pkg::hyper_req_t   trans_req_i,
    input  hyper_pkg::hyper_wdata_t wdata_i,
    input  logic                    wempty_i,
    output logic                    wpop_o,
    input  logic                    rfull_i,
    output logic [15:0]             out_word_o,
    output logic [1:0]              out_mask_o,
    output logic                    byte_sel_o,
    output logic                    ck_en_o,
    output logic                    capture_en_o,
    output logic                    dq_oe_o,
    output logic                    rwds_oe_o,
    output logic [NR_CS-1:0]        cs_no
);

    localparam int unsigned LAT_CYCLES = 2 * WAIT_CYCLES; // two bytes per ck period
    localparam int unsigned CNT_W = $clog2(LAT_CYCLES + hyper_pkg::T_RWR_CYCLES + 8);

    hyper_pkg::hyper_state_e state_q;
    hyper_pkg::hyper_state_e state_d;
    hyper_pkg::hyper_req_t   req_q;
    hyper_pkg::hyper_wdata_t wreg_q;
    logic [47:0]             ca;
    logic [CNT_W-1:0]        cnt_q;
    logic [CNT_W-1:0]        cnt_d;
    logic [11:0]             burst_q; // words left after the current one
    logic [11:0]             burst_d;
    logic                    half_q;  // 0 = high byte
    logic                    half_d;
    logic                    cs_act_q;
    logic                    reg_wr;
    logic                    start;   // word boundary, next word may begin
    logic                    drive_dq;
    logic                    drive_rwds;
    logic                    capture;
    logic                    dq_oe_q;
    logic                    rwds_oe_q;
    logic                    capture_q;

    assign ca            = hyper_pkg::ca_word(req_q);
    assign reg_wr        = req_q.reg_space && req_q.write;
    assign trans_ready_o = (state_q == hyper_pkg::IDLE);
    assign cs_no         = cs_act_q ? ~req_q.cs[NR_CS-1:0] : '1;
    assign wpop_o        = start && req_q.write && !wempty_i;
    assign dq_oe_o       = dq_oe_q;
    assign rwds_oe_o     = rwds_oe_q;
    assign capture_en_o  = capture_q;

    always_comb begin
        state_d = state_q;
        cnt_d   = cnt_q;
        burst_d = burst_q;
        half_d  = half_q;
        start   = 1'b0;
        case (state_q)
            hyper_pkg::IDLE: begin
                if (trans_valid_i) begin
                    state_d = hyper_pkg::CMD;
                    cnt_d   = '0;
                end
            end
            hyper_pkg::CMD: begin
                cnt_d = cnt_q + 1'b1;
                if (cnt_q == CNT_W'(5)) begin
                    cnt_d   = '0;
                    burst_d = reg_wr ? 12'd0 : req_q.burst - 12'd1;
                    if (reg_wr) begin
                        start = 1'b1; // register write, no latency
                    end else begin
                        state_d = hyper_pkg::LATENCY;
                    end
                end
            end
            hyper_pkg::LATENCY: begin
                cnt_d = cnt_q + 1'b1;
                start = (cnt_q == CNT_W'(LAT_CYCLES - 1));
            end
            hyper_pkg::DATA_W, hyper_pkg::DATA_R: begin
                half_d = ~half_q;
                if (half_q && burst_q != 12'd0) begin
                    burst_d = burst_q - 12'd1;
                    start   = 1'b1;
                end else if (half_q) begin
                    state_d = hyper_pkg::RECOVER;
                    cnt_d   = '0;
                end
            end
            hyper_pkg::STALL_W, hyper_pkg::STALL_R: start = 1'b1; // retry each cycle
            hyper_pkg::RECOVER: begin
                cnt_d = cnt_q + 1'b1;
                if (cnt_q == CNT_W'(hyper_pkg::T_RWR_CYCLES))
                    state_d = hyper_pkg::IDLE;
            end
            default: state_d = hyper_pkg::IDLE;
        endcase
        if (start) begin
            half_d = 1'b0;
            if (req_q.write)
                state_d = wempty_i ? hyper_pkg::STALL_W : hyper_pkg::DATA_W;
            else
                state_d = rfull_i ? hyper_pkg::STALL_R : hyper_pkg::DATA_R;
        end
    end

    always_comb begin
        out_word_o = wreg_q.data;
        out_mask_o = 2'b00;
        byte_sel_o = half_q;
        ck_en_o    = 1'b0;
        drive_dq   = 1'b0;
        drive_rwds = 1'b0;
        capture    = 1'b0;
        case (state_q)
            hyper_pkg::CMD: begin
                ck_en_o    = 1'b1;
                drive_dq   = 1'b1;
                byte_sel_o = cnt_q[0];
                case (cnt_q[2:1])
                    2'd0:    out_word_o = ca[47:32];
                    2'd1:    out_word_o = ca[31:16];
                    default: out_word_o = ca[15:0];
                endcase
            end
            hyper_pkg::LATENCY: ck_en_o = 1'b1;
            hyper_pkg::DATA_W, hyper_pkg::STALL_W: begin
                ck_en_o    = (state_q == hyper_pkg::DATA_W);
                drive_dq   = 1'b1; // bus held during a stall
                drive_rwds = 1'b1;
                out_mask_o = ~wreg_q.strb; // rwds high masks the byte
            end
            hyper_pkg::DATA_R, hyper_pkg::STALL_R: begin
                ck_en_o = (state_q == hyper_pkg::DATA_R);
                capture = 1'b1;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk0 or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q   <= hyper_pkg::IDLE;
            cnt_q     <= '0;
            burst_q   <= '0;
            half_q    <= 1'b0;
            cs_act_q  <= 1'b0;
            dq_oe_q   <= 1'b0;
            rwds_oe_q <= 1'b0;
            capture_q <= 1'b0;
        end else begin
            state_q   <= state_d;
            cnt_q     <= cnt_d;
            burst_q   <= burst_d;
            half_q    <= half_d;
            dq_oe_q   <= drive_dq;  // aligned with the registered pins
            rwds_oe_q <= drive_rwds;
            capture_q <= capture;
            if (trans_valid_i && trans_ready_o) begin
                cs_act_q <= 1'b1;
            end else if (state_q == hyper_pkg::RECOVER && cnt_q == '0) begin
                cs_act_q <= 1'b0; // last byte has left the pins
            end
        end
    end

    always_ff @(posedge clk0) begin
        if (trans_valid_i && trans_ready_o)
            req_q <= trans_req_i;
        if (wpop_o)
            wreg_q <= wdata_i;
    end

    a_cs_onehot: assert property (@(posedge clk0) disable iff (!rst_ni)
        $onehot(~cs_no) || (&cs_no));

    a_no_drive_on_read: assert property (@(posedge clk0) disable iff (!rst_ni)
        !(dq_oe_o && capture_en_o));

endmodule

/* src/hyper_ddr_io.sv */
`timescale 1ns/10ps

// byte-wide I/O for the HyperBus pins
// one byte per clk0 out, ck toggles per enabled cycle, read bytes taken on rwds changes

module hyper_ddr_io (
    input  logic        clk0,
    input  logic        rst_ni,
    input  logic [15:0] out_word_i,
    input  logic [1:0]  out_mask_i,
    input  logic        byte_sel_i,   // 0 = high byte
    input  logic        ck_en_i,
    input  logic        capture_en_i,
    input  logic [7:0]  hyper_dq_i,
    input  logic        hyper_rwds_i,
    output logic [7:0]  hyper_dq_o,
    output logic        hyper_rwds_o,
    output logic        hyper_ck_o,
    output logic        hyper_ck_no,
    output logic [15:0] word_o,
    output logic        word_valid_o
);

    logic       ck_q;
    logic       rwds_last_q;
    logic       hi_seen_q; // high byte of the pair already taken
    logic [7:0] hi_byte_q;
    logic       rwds_edge;

    assign hyper_ck_o  = ck_q;
    assign hyper_ck_no = ~ck_q;
    assign rwds_edge   = capture_en_i && (hyper_rwds_i != rwds_last_q);

    always_ff @(posedge clk0 or negedge rst_ni) begin
        if (!rst_ni) begin
            hyper_dq_o   <= '0;
            hyper_rwds_o <= 1'b0;
            ck_q         <= 1'b0;
        end else begin
            hyper_dq_o   <= byte_sel_i ? out_word_i[7:0] : out_word_i[15:8];
            hyper_rwds_o <= byte_sel_i ? out_mask_i[0] : out_mask_i[1];
            if (ck_en_i)
                ck_q <= ~ck_q;
        end
    end

    always_ff @(posedge clk0 or negedge rst_ni) begin
        if (!rst_ni) begin
            rwds_last_q  <= 1'b0;
            hi_seen_q    <= 1'b0;
            word_valid_o <= 1'b0;
        end else begin
            rwds_last_q  <= hyper_rwds_i;
            word_valid_o <= rwds_edge && hi_seen_q;
            if (!capture_en_i)
                hi_seen_q <= 1'b0; // restart pairing per transaction
            else if (rwds_edge)
                hi_seen_q <= ~hi_seen_q;
        end
    end

    always_ff @(posedge clk0) begin
        if (rwds_edge && !hi_seen_q)
            hi_byte_q <= hyper_dq_i;
        if (rwds_edge && hi_seen_q)
            word_o <= {hi_byte_q, hyper_dq_i};
    end

endmodule

/* src/hyper_rx_fifo.sv */
`timescale 1ns/10ps

// read FIFO for words captured from the device
// almost_full leaves room for the words still in flight when the clock stops

module hyper_rx_fifo #(
    parameter int unsigned FIFO_DEPTH = 8 // power of two
) (
    input  logic        clk0,
    input  logic        rst_ni,
    input  logic        push_i,
    input  logic [15:0] data_i,
    output logic        almost_full_o,
    output logic        valid_o,
    input  logic        ready_i,
    output logic [15:0] data_o
);

    localparam int unsigned PTR_W = $clog2(FIFO_DEPTH);

    logic [15:0]    mem [FIFO_DEPTH];
    logic [PTR_W:0] wr_ptr_q;
    logic [PTR_W:0] rd_ptr_q;
    logic [PTR_W:0] count;

    assign count         = wr_ptr_q - rd_ptr_q;
    assign almost_full_o = (count > (PTR_W+1)'(FIFO_DEPTH - 2)); // under two free
    assign valid_o       = (count != '0);
    assign data_o        = mem[rd_ptr_q[PTR_W-1:0]];

    always_ff @(posedge clk0 or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (push_i)
                wr_ptr_q <= wr_ptr_q + 1'b1;
            if (valid_o && ready_i)
                rd_ptr_q <= rd_ptr_q + 1'b1;
        end
    end

    always_ff @(posedge clk0) begin
        if (push_i)
            mem[wr_ptr_q[PTR_W-1:0]] <= data_i;
    end

    a_no_push_full: assert property (@(posedge clk0) disable iff (!rst_ni)
        push_i |-> (count != (PTR_W+1)'(FIFO_DEPTH)));

endmodule

/* src/hyper_tx_fifo.sv */
`timescale 1ns/10ps

// write FIFO between the tx channel and the FSM
// empty flag makes the FSM stop the device clock at a word boundary

module hyper_tx_fifo #(
    parameter int unsigned FIFO_DEPTH = 8 // power of two
) (
    input  logic                    clk0,
    input  logic                    rst_ni,
    input  logic                    valid_i,
    output logic                    ready_o,
    input  hyper_pkg::hyper_wdata_t data_i,
    input  logic                    pop_i,
    output hyper_pkg::hyper_wdata_t data_o,
    output logic                    empty_o
);

    localparam int unsigned PTR_W = $clog2(FIFO_DEPTH);

    hyper_pkg::hyper_wdata_t mem [FIFO_DEPTH];
    logic [PTR_W:0]          wr_ptr_q;
    logic [PTR_W:0]          rd_ptr_q;
    logic [PTR_W:0]          count;

    assign count   = wr_ptr_q - rd_ptr_q; // extra bit tells full from empty
    assign ready_o = (count != (PTR_W+1)'(FIFO_DEPTH));
    assign empty_o = (count == '0);
    assign data_o  = mem[rd_ptr_q[PTR_W-1:0]];

    always_ff @(posedge clk0 or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (valid_i && ready_o)
                wr_ptr_q <= wr_ptr_q + 1'b1;
            if (pop_i)
                rd_ptr_q <= rd_ptr_q + 1'b1;
        end
    end

    always_ff @(posedge clk0) begin
        if (valid_i && ready_o)
            mem[wr_ptr_q[PTR_W-1:0]] <= data_i;
    end

    a_no_pop_empty: assert property (@(posedge clk0) disable iff (!rst_ni)
        pop_i |-> !empty_o);

endmodule

/* src/hyper_pkg.sv */
// shared types and constants for the HyperBus PHY
// request and write-data structs, FSM states, CA field layout, timing

package hyper_pkg;

    localparam int unsigned MAX_CS       = 2;
    localparam int unsigned CA_RW_BIT    = 47; // 1 = read
    localparam int unsigned CA_SPACE_BIT = 46; // 1 = register space
    localparam int unsigned CA_BURST_BIT = 45; // 1 = linear burst
    localparam int unsigned T_RWR_CYCLES = 6;

    typedef struct packed {
        logic [31:0]       addr;      // half-word address
        logic [MAX_CS-1:0] cs;        // one-hot
        logic              write;
        logic              reg_space;
        logic [11:0]       burst;     // words, at least 1
    } hyper_req_t;

    typedef struct packed {
        logic [15:0] data;
        logic [1:0]  strb; // bit 1 is the high byte, sent first
    } hyper_wdata_t;

    typedef enum logic [2:0] {
        IDLE, CMD, LATENCY, DATA_W, DATA_R, STALL_W, STALL_R, RECOVER
    } hyper_state_e;

    // 48-bit command/address word
    function automatic logic [47:0] ca_word(input hyper_req_t req);
        logic [47:0] ca;
        ca               = '0;
        ca[CA_RW_BIT]    = ~req.write;
        ca[CA_SPACE_BIT] = req.reg_space;
        ca[CA_BURST_BIT] = 1'b1;
        ca[44:16]        = req.addr[31:3];
        ca[2:0]          = req.addr[2:0]; // word within the row
        return ca;
    endfunction

endpackage
